//--- design/lb_defs.svh
//--------------------
// sizing macros for the job load balancer: worker count,
// field widths, job fifo depth and the per-worker load capacity
//--------------------
`ifndef LB_DEFS_SVH
`define LB_DEFS_SVH

// size of the worker pool and the width of an index into it
`define LB_WORKERS 4
`define LB_WORKER_W 2

// widths of the job fields, where a credit amount is as wide as the cost
`define LB_COST_W 8
`define LB_TAG_W 16

// load counters are wider than the cost so that load plus cost never wraps
`define LB_LOAD_W 10
`define LB_CAPACITY 255

// the job fifo level has to hold the value of the depth itself
`define LB_FIFO_DEPTH 8
`define LB_FIFO_LVL_W 4

`endif

//--- design/lb_pkg.sv
//--------------------
// shared types of the load balancer: job, credit return,
// host write word, configuration, dispatch record, address map
//--------------------
`default_nettype none

`include "lb_defs.svh"

package lb_pkg;

  // one unit of work as written by the host
  typedef struct packed {
    logic [`LB_TAG_W-1:0]    tag;
    logic [`LB_COST_W-1:0]   cost;
  } job_t;

  // a credit return is padded so that it lines up with job_t
  typedef struct packed {
    logic [`LB_TAG_W-`LB_WORKER_W-1:0] pad;
    logic [`LB_WORKER_W-1:0]           worker;
    logic [`LB_COST_W-1:0]             amount;
  } credit_t;

  // the low bits of a host write are a job or a credit, the address decides which
  typedef union packed {
    job_t    job;
    credit_t credit;
  } wb_wdata_u;

  // pack_mode 0 spreads jobs, 1 packs them onto the busiest worker that fits
  typedef struct packed {
    logic                    pack_mode;
    logic [`LB_WORKERS-1:0]  online;
  } lb_cfg_t;

  typedef struct packed {
    logic [`LB_WORKER_W-1:0] worker;
    logic [`LB_TAG_W-1:0]    tag;
    logic [`LB_COST_W-1:0]   cost;
  } dispatch_t;

  typedef enum logic [1:0] {
    ADDR_JOB    = 2'd0,
    ADDR_CREDIT = 2'd1,
    ADDR_CFG    = 2'd2,
    ADDR_STATUS = 2'd3
  } wb_addr_e;

endpackage

`default_nettype wire

//--- design/lb_minmax.sv
//--------------------
// combinational selector that picks the smallest or largest
// enabled entry of a packed array and reports its value and index
//--------------------
`timescale 1ns/1ps
`default_nettype none

module lb_minmax #(
  parameter int word_cnt   = 4,
  parameter int word_width = 10,
  parameter int index_w    = (word_cnt > 1) ? $clog2(word_cnt) : 1
) (
  input  logic [word_cnt*word_width-1:0] array,
  input  logic [word_cnt-1:0]            enable,
  input  logic                           min_max,
  output logic                           valid,
  output logic [word_width-1:0]          value,
  output logic [index_w-1:0]             index
);

  // the tree is a full binary heap, node 0 is the root and node n has
  // children 2n+1 and 2n+2, leaves past word_cnt are padding
  localparam int leaf_cnt = 1 << index_w;
  localparam int node_cnt = 2 * leaf_cnt - 1;

  logic [word_width:0] node_val [node_cnt];
  logic [index_w-1:0]  node_idx [node_cnt];

  //--------------------
  // leaves
  //--------------------
  // every entry gets one extra top bit so that a disabled entry loses
  // against any enabled one, for min the bit is set on disabled entries
  // and for max it is set on enabled entries
  for (genvar j = 0; j < leaf_cnt; j++) begin : g_leaf
    if (j < word_cnt) begin : g_entry
      assign node_val[leaf_cnt-1+j] = {enable[j] == min_max, array[j*word_width +: word_width]};
    end else begin : g_pad
      // padding sits at the far end of the order and can only win when nothing is enabled
      assign node_val[leaf_cnt-1+j] = {(word_width+1){~min_max}};
    end
    assign node_idx[leaf_cnt-1+j] = index_w'(j);
  end

  //--------------------
  // comparator tree
  //--------------------
  // the left subtree always holds the lower indices, so a tie keeps the
  // left side for min and moves to the right side for max
  for (genvar n = 0; n < leaf_cnt - 1; n++) begin : g_node
    logic take_right;

    assign take_right = min_max ? (node_val[2*n+2] >= node_val[2*n+1]) :
                                  (node_val[2*n+2] <  node_val[2*n+1]);
    assign node_val[n] = take_right ? node_val[2*n+2] : node_val[2*n+1];
    assign node_idx[n] = take_right ? node_idx[2*n+2] : node_idx[2*n+1];
  end

  // the ordering bit of the root is dropped, only the payload bits leave
  assign value = node_val[0][word_width-1:0];
  assign index = node_idx[0];
  assign valid = |enable;

  // a valid answer must point at an entry that was actually enabled,
  // which depends on the ordering bit and the tie rules working together
  always_comb begin
    a_valid_enabled: assert final (!valid || enable[index])
      else $error("lb_minmax: winner index %0d is not enabled", index);
  end

endmodule

`default_nettype wire

//--- design/lb_wb_ingress.sv
//--------------------
// wishbone classic slave of the load balancer that turns
// host writes into jobs, credits and configuration and
// answers reads with the status word
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "lb_defs.svh"

module lb_wb_ingress (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [1:0]                wb_adr,
  input  logic [31:0]               wb_dat_w,
  output logic [31:0]               wb_dat_r,
  output logic                      wb_ack,
  input  logic                      fifo_full,
  input  logic [`LB_FIFO_LVL_W-1:0] fifo_level,
  output logic                      job_push,
  output lb_pkg::job_t              job,
  output logic                      credit_valid,
  output lb_pkg::credit_t           credit,
  output lb_pkg::lb_cfg_t           cfg
);
  import lb_pkg::*;

  wb_addr_e   adr;
  wb_wdata_u  wdata;
  logic       req;
  logic       accept;
  logic       wr_job;
  logic       wr_credit;
  logic       wr_cfg;
  logic [31:0] status_word;

  // a new request is one that has not been acknowledged yet, so the
  // cycle that carries ack never starts a second access
  assign req   = wb_cyc && wb_stb && !wb_ack;
  assign adr   = wb_addr_e'(wb_adr);
  assign wdata = wb_wdata_u'(wb_dat_w[$bits(wb_wdata_u)-1:0]);

  // job writes wait here while the fifo has no free slot, every
  // other access completes on the next edge
  assign accept = req && !(wb_we && adr == ADDR_JOB && fifo_full);

  assign wr_job    = accept && wb_we && adr == ADDR_JOB;
  assign wr_credit = accept && wb_we && adr == ADDR_CREDIT;
  assign wr_cfg    = accept && wb_we && adr == ADDR_CFG;

  // the status word carries the fifo level in bits 3:0 and sets bit 4 when the fifo is empty
  assign status_word = {{(31 - `LB_FIFO_LVL_W){1'b0}}, fifo_level == '0, fifo_level};

  //--------------------
  // control
  //--------------------
  // push and credit strobes line up with ack, so the fifo takes the job
  // and the load table takes the credit at the end of the ack cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack         <= 1'b0;
      job_push       <= 1'b0;
      credit_valid   <= 1'b0;
      cfg.pack_mode  <= 1'b0;
      cfg.online     <= '1;
    end else begin
      wb_ack       <= accept;
      job_push     <= wr_job;
      credit_valid <= wr_credit;
      if (wr_cfg) begin
        cfg <= lb_cfg_t'(wb_dat_w[$bits(lb_cfg_t)-1:0]);
      end
    end
  end

  //--------------------
  // payload
  //--------------------
  // both views of the write word are captured, only the one whose strobe fires is used
  always_ff @(posedge clk) begin
    if (accept) begin
      job      <= wdata.job;
      credit   <= wdata.credit;
      wb_dat_r <= status_word;
    end
  end

  // ack must only ever answer a live cycle of the host
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("lb_wb_ingress: ack without cyc and stb");

endmodule

`default_nettype wire

//--- design/lb_job_fifo.sv
//--------------------
// synchronous circular buffer of jobs with
// full, empty and level outputs
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "lb_defs.svh"

module lb_job_fifo (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      push,
  input  lb_pkg::job_t              push_job,
  input  logic                      pop,
  output lb_pkg::job_t              head,
  output logic                      empty,
  output logic                      full,
  output logic [`LB_FIFO_LVL_W-1:0] level
);
  import lb_pkg::*;

  localparam int ptr_w = $clog2(`LB_FIFO_DEPTH);

  job_t             mem [`LB_FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;

  //--------------------
  // pointers and level
  //--------------------
  // the pointers wrap explicitly so the depth need not be a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(`LB_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(`LB_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the level where it is
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  //--------------------
  // storage
  //--------------------
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_job;
    end
  end

  // the head is read straight from the array, a job written on one
  // edge is visible there during the following cycle
  assign head  = mem[rd_ptr];
  assign empty = (level == '0);
  assign full  = (level == `LB_FIFO_LVL_W'(`LB_FIFO_DEPTH));

  // the ingress checks full and the dispatcher checks empty before acting
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    push |-> !full)
    else $error("lb_job_fifo: push while full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty)
    else $error("lb_job_fifo: pop while empty");

endmodule

`default_nettype wire

//--- design/lb_dispatch.sv
//--------------------
// per-worker load table, eligibility of the head
// job, worker selection and the registered dispatch output
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "lb_defs.svh"

module lb_dispatch (
  input  logic               clk,
  input  logic               reset,
  input  lb_pkg::job_t       head,
  input  logic               empty,
  output logic               pop,
  input  lb_pkg::lb_cfg_t    cfg,
  input  logic               credit_valid,
  input  lb_pkg::credit_t    credit,
  output logic               out_valid,
  input  logic               out_ready,
  output lb_pkg::dispatch_t  out
);
  import lb_pkg::*;

  logic [`LB_LOAD_W-1:0]             load [`LB_WORKERS];
  logic [`LB_WORKERS*`LB_LOAD_W-1:0] load_vec;
  logic [`LB_WORKERS-1:0]            eligible;
  logic                              sel_valid;
  logic [`LB_LOAD_W-1:0]             sel_value;
  logic [`LB_WORKER_W-1:0]           sel_index;
  logic                              stage_free;

  //--------------------
  // load table
  //--------------------
  for (genvar i = 0; i < `LB_WORKERS; i++) begin : g_worker
    logic [`LB_LOAD_W:0]   room_sum;
    logic [`LB_LOAD_W-1:0] after_pop;
    logic [`LB_LOAD_W-1:0] after_credit;

    // one spare bit keeps load plus cost from wrapping before the compare
    assign room_sum    = load[i] + head.cost;
    assign eligible[i] = cfg.online[i] && (room_sum <= `LB_CAPACITY);
    assign load_vec[i*`LB_LOAD_W +: `LB_LOAD_W] = load[i];

    // the selector already returns the chosen load, so the new value is built from it
    assign after_pop = (pop && sel_index == i) ? sel_value + head.cost : load[i];

    // when a pop and a credit hit the same worker on one edge the cost
    // goes on first and the credit comes off after, never below zero
    assign after_credit = !(credit_valid && credit.worker == i) ? after_pop :
                          (after_pop > credit.amount) ? after_pop - credit.amount : '0;

    always_ff @(posedge clk) begin
      if (reset) begin
        load[i] <= '0;
      end else begin
        load[i] <= after_credit;
      end
    end

    // eligibility in front of the selector is what keeps every load in range
    a_load_cap: assert property (@(posedge clk) disable iff (reset)
      load[i] <= `LB_CAPACITY)
      else $error("lb_dispatch: worker %0d load %0d over capacity", i, load[i]);
  end

  //--------------------
  // selection
  //--------------------
  // spread mode wants the smallest load, pack mode the largest that still fits
  lb_minmax #(
    .word_cnt   (`LB_WORKERS),
    .word_width (`LB_LOAD_W)
  ) i_minmax (
    .array   (load_vec),
    .enable  (eligible),
    .min_max (cfg.pack_mode),
    .valid   (sel_valid),
    .value   (sel_value),
    .index   (sel_index)
  );

  // the output register can take a new job when it is empty or being drained now
  assign stage_free = !out_valid || out_ready;
  assign pop        = !empty && sel_valid && stage_free;

  //--------------------
  // output stage
  //--------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (pop) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // the payload only moves on a pop, so it holds while ready is low
  always_ff @(posedge clk) begin
    if (pop) begin
      out.worker <= sel_index;
      out.tag    <= head.tag;
      out.cost   <= head.cost;
    end
  end

endmodule

`default_nettype wire

//--- design/lb_top.sv
//--------------------
// job load balancer top level, a wishbone ingress feeding a
// job fifo that the dispatcher drains onto the dispatch port
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "lb_defs.svh"

module lb_top (
  input  logic               clk,
  input  logic               reset,
  // host side, wishbone classic
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  logic [1:0]         wb_adr,
  input  logic [31:0]        wb_dat_w,
  output logic [31:0]        wb_dat_r,
  output logic               wb_ack,
  // dispatch stream
  output logic               out_valid,
  input  logic               out_ready,
  output lb_pkg::dispatch_t  out
);
  import lb_pkg::*;

  job_t                      push_job;
  job_t                      head;
  credit_t                   credit;
  lb_cfg_t                   cfg;
  logic                      job_push;
  logic                      job_pop;
  logic                      credit_valid;
  logic                      fifo_full;
  logic                      fifo_empty;
  logic [`LB_FIFO_LVL_W-1:0] fifo_level;

  // producer of jobs, credits and configuration
  lb_wb_ingress i_ingress (
    .clk          (clk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .fifo_full    (fifo_full),
    .fifo_level   (fifo_level),
    .job_push     (job_push),
    .job          (push_job),
    .credit_valid (credit_valid),
    .credit       (credit),
    .cfg          (cfg)
  );

  lb_job_fifo i_fifo (
    .clk      (clk),
    .reset    (reset),
    .push     (job_push),
    .push_job (push_job),
    .pop      (job_pop),
    .head     (head),
    .empty    (fifo_empty),
    .full     (fifo_full),
    .level    (fifo_level)
  );

  // consumer that assigns the head job to a worker
  lb_dispatch i_dispatch (
    .clk          (clk),
    .reset        (reset),
    .head         (head),
    .empty        (fifo_empty),
    .pop          (job_pop),
    .cfg          (cfg),
    .credit_valid (credit_valid),
    .credit       (credit),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out          (out)
  );

endmodule

`default_nettype wire

//--- verif/lb_tb.sv
//--------------------
// testbench of the job load balancer with table driven host
// traffic, a reference model of the worker choice and a dispatch monitor
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "lb_defs.svh"

module lb_tb;
  import lb_pkg::*;

  localparam int ack_limit   = 200;
  localparam int drain_limit = 1000;

  // row kinds of the stimulus table
  localparam logic [2:0] op_job    = 3'd0;
  localparam logic [2:0] op_credit = 3'd1;
  localparam logic [2:0] op_cfg    = 3'd2;
  localparam logic [2:0] op_status = 3'd3;
  localparam logic [2:0] op_hold   = 3'd4;
  localparam logic [2:0] op_drain  = 3'd5;

  // a is the tag, worker, config word, expected status or hold length, b is cost or amount
  typedef struct packed {
    logic [2:0]  op;
    logic [15:0] a;
    logic [15:0] b;
  } row_t;

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        out_valid;
  logic        out_ready;
  dispatch_t   dispatch_out;

  row_t                   table_q [$];
  dispatch_t              exp_q [$];
  job_t                   model_q [$];
  int                     model_load [`LB_WORKERS];
  logic                   model_pack;
  logic [`LB_WORKERS-1:0] model_online;
  int                     hold_cycles = 0;
  int                     err_cnt = 0;
  int                     timeout_cnt = 0;
  int                     dispatch_cnt = 0;
  int                     job_cnt = 0;
  logic [31:0]            rdata;

  lb_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out       (dispatch_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // out_ready is random by default, a hold keeps it low for a number of cycles
  initial begin
    void'($urandom(32'hb89e));
    out_ready = 1'b0;
    forever begin
      @(posedge clk);
      if (hold_cycles > 0) begin
        out_ready <= 1'b0;
        hold_cycles = hold_cycles - 1;
      end else begin
        out_ready <= ($urandom % 4) != 0;
      end
    end
  end

  //--------------------
  // compare tasks
  //--------------------
  task automatic check_dispatch(input dispatch_t got, input dispatch_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t: dispatch %0d/%h/%0d, expected %0d/%h/%0d (worker/tag/cost)",
               $time, got.worker, got.tag, got.cost, exp.worker, exp.tag, exp.cost);
    end
  endtask

  task automatic check_status(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t: status word %h, expected %h", $time, got, exp);
    end
  endtask

  // every accepted transfer on the dispatch port is matched in order against the model
  always @(posedge clk) begin
    if (!reset && out_valid === 1'b1 && out_ready === 1'b1) begin
      dispatch_cnt++;
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("unexpected dispatch at %0t of tag %h, the model predicted none",
                 $time, dispatch_out.tag);
      end else begin
        check_dispatch(dispatch_out, exp_q.pop_front());
      end
    end
  end

  //--------------------
  // reference model
  //--------------------
  // a worker must be online and stay within capacity, spread picks the lowest
  // load with the lowest index winning ties, pack the highest load with the highest index
  function automatic int pick_worker(input int cost);
    int best;
    best = -1;
    for (int w = 0; w < `LB_WORKERS; w++) begin
      if (model_online[w] && model_load[w] + cost <= `LB_CAPACITY) begin
        if (best < 0) begin
          best = w;
        end else if (!model_pack && model_load[w] < model_load[best]) begin
          best = w;
        end else if (model_pack && model_load[w] >= model_load[best]) begin
          best = w;
        end
      end
    end
    return best;
  endfunction

  // the head job blocks every job behind it until it finds a worker
  task automatic advance_model();
    dispatch_t d;
    int        w;
    while (model_q.size() > 0) begin
      w = pick_worker(int'(model_q[0].cost));
      if (w < 0) begin
        break;
      end
      d.worker = `LB_WORKER_W'(w);
      d.tag    = model_q[0].tag;
      d.cost   = model_q[0].cost;
      model_load[w] += int'(model_q[0].cost);
      exp_q.push_back(d);
      model_q.delete(0);
    end
  endtask

  //--------------------
  // wishbone host
  //--------------------
  // the cycle is ended on the same edge that shows ack
  task automatic wait_ack(input string what);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (wb_ack !== 1'b1 && cycles < ack_limit);
    if (wb_ack !== 1'b1) begin
      timeout_cnt++;
      $display("timeout at %0t: the %s was never acknowledged", $time, what);
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input wb_addr_e adr, input logic [31:0] data, input string what);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= data;
    wait_ack(what);
  endtask

  task automatic wb_read(input wb_addr_e adr, output logic [31:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    wait_ack("status read");
    data = wb_dat_r;
  endtask

  // waits on falling edges until every predicted dispatch has left the port
  task automatic drain();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (exp_q.size() > 0 && cycles < drain_limit);
    if (exp_q.size() > 0) begin
      timeout_cnt++;
      $display("timeout at %0t: %0d predicted dispatch(es) never came out", $time, exp_q.size());
    end
  endtask

  task automatic add_row(input logic [2:0] op, input logic [15:0] a, input logic [15:0] b);
    row_t r;
    r.op = op;
    r.a  = a;
    r.b  = b;
    table_q.push_back(r);
  endtask

  //--------------------
  // stimulus table
  //--------------------
  task automatic build_table();
    // spread mode with all workers online, then saturating and partial credits
    add_row(op_job, 16'h0101, 50);
    add_row(op_job, 16'h0102, 30);
    add_row(op_job, 16'h0103, 20);
    add_row(op_job, 16'h0104, 40);
    add_row(op_job, 16'h0105, 10);
    add_row(op_job, 16'h0106, 5);
    add_row(op_drain, 0, 0);
    add_row(op_status, 16'h0010, 0);
    add_row(op_credit, 0, 200);
    add_row(op_credit, 3, 15);
    add_row(op_job, 16'h0107, 60);
    add_row(op_job, 16'h0108, 25);
    // pack mode fills worker 0 to the limit, then ties go to the highest index
    add_row(op_cfg, 16'h001f, 0);
    add_row(op_job, 16'h0201, 100);
    add_row(op_job, 16'h0202, 95);
    add_row(op_job, 16'h0203, 10);
    add_row(op_job, 16'h0204, 20);
    add_row(op_credit, 3, 45);
    add_row(op_job, 16'h0205, 5);
    // only workers 0 and 2 online
    add_row(op_cfg, 16'h0005, 0);
    add_row(op_job, 16'h0301, 20);
    add_row(op_job, 16'h0302, 10);
    add_row(op_credit, 0, 255);
    add_row(op_job, 16'h0303, 7);
    // a single online worker runs out of room until a credit frees it
    add_row(op_cfg, 16'h0002, 0);
    add_row(op_job, 16'h0401, 200);
    add_row(op_job, 16'h0402, 30);
    add_row(op_drain, 0, 0);
    add_row(op_status, 16'h0001, 0);
    add_row(op_credit, 1, 50);
    add_row(op_drain, 0, 0);
    add_row(op_status, 16'h0010, 0);
    // back-pressure fills the fifo, the last two writes stall until ready returns
    add_row(op_cfg, 16'h000f, 0);
    add_row(op_credit, 1, 255);
    add_row(op_hold, 60, 0);
    for (int k = 1; k <= 9; k++) begin
      add_row(op_job, 16'h0500 + 16'(k), 10);
    end
    add_row(op_status, 16'h0008, 0);
    add_row(op_job, 16'h050a, 10);
    add_row(op_job, 16'h050b, 10);
    add_row(op_drain, 0, 0);
    add_row(op_status, 16'h0010, 0);
  endtask

  task automatic finish_run();
    $display("dispatches %0d, mismatches %0d, timeouts %0d", dispatch_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  initial begin
    row_t    row;
    job_t    job;
    credit_t credit;
    lb_cfg_t cfg;
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    model_pack   = 1'b0;
    model_online = '1;
    foreach (model_load[w]) begin
      model_load[w] = 0;
    end
    build_table();
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    foreach (table_q[i]) begin
      if (timeout_cnt > 0) begin
        break;
      end
      row = table_q[i];
      case (row.op)
        op_job: begin
          job.tag  = row.a;
          job.cost = row.b[`LB_COST_W-1:0];
          wb_write(ADDR_JOB, 32'(job), "job write");
          job_cnt++;
          model_q.push_back(job);
          advance_model();
        end
        op_credit: begin
          // credits only arrive once the decided jobs have left
          drain();
          credit        = '0;
          credit.worker = row.a[`LB_WORKER_W-1:0];
          credit.amount = row.b[`LB_COST_W-1:0];
          wb_write(ADDR_CREDIT, 32'(credit), "credit write");
          if (model_load[credit.worker] > int'(credit.amount)) begin
            model_load[credit.worker] -= int'(credit.amount);
          end else begin
            model_load[credit.worker] = 0;
          end
          advance_model();
        end
        op_cfg: begin
          drain();
          cfg = lb_cfg_t'(row.a[$bits(lb_cfg_t)-1:0]);
          wb_write(ADDR_CFG, 32'(cfg), "configuration write");
          model_pack   = cfg.pack_mode;
          model_online = cfg.online;
          advance_model();
        end
        op_status: begin
          wb_read(ADDR_STATUS, rdata);
          check_status(rdata, 32'(row.a));
        end
        op_hold: begin
          drain();
          hold_cycles = int'(row.a);
        end
        default: begin
          drain();
        end
      endcase
    end

    drain();
    // every job that the host wrote has to leave the dispatch port exactly once
    if (dispatch_cnt != job_cnt) begin
      err_cnt++;
      $display("%0d job(s) were written but %0d left the dispatch port", job_cnt, dispatch_cnt);
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/lb_pkg.sv
design/lb_minmax.sv
design/lb_wb_ingress.sv
design/lb_job_fifo.sv
design/lb_dispatch.sv
design/lb_top.sv
verif/lb_tb.sv

//--- Makefile
# Verilator build and run of the job load balancer testbench

VERILATOR ?= verilator
TOP       ?= lb_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Simulation finished: PASS

SOURCES := $(wildcard design/*.sv design/*.svh verif/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, a missing pass line fails the target
run: $(BINARY)
	./$(BINARY) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
